// ==== tb.f ====
design/bus_pkg.sv
design/soc_map_pkg.sv
design/periph_if.sv
design/bus_ctrl.sv
design/ram_port.sv
design/plic.sv
design/soc_bus.sv
sim/soc_bus_properties.sv
sim/tb_soc_bus.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := tb_soc_bus
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus;
    import bus_pkg::*;
    import soc_map_pkg::*;

    // six tests take about 400 cycles
    localparam int cycle_limit = 2000;

    logic CLOCK_50;
    logic KEY0;
    logic [xlen-1:0] bus_address;
    ls_type_e bus_ls_type;
    logic [xlen-1:0] bus_write_data;
    logic bus_read_enable;
    logic bus_write_enable;
    logic [xlen-1:0] bus_read_data;
    logic bus_read_done;
    logic bus_write_done;
    logic [7:0] key_ascii;
    logic [xlen-1:0] mtime;
    logic [xlen-1:0] mtimecmp;
    logic uart_irq;
    logic meip_interrupt;
    logic msip_interrupt;
    int cycle_count = 0;

    soc_bus soc_bus_i (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, a bus access never completed", cycle_count);
            $display("Checks failed");
            $fatal(1, "run limit reached");
        end
    end

    task automatic compare_values(input string name, input logic [xlen-1:0] expected,
                                  input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "wrong value in %s", name);
        end
    endtask

    function automatic logic [xlen-1:0] sign_extend(input logic [xlen-1:0] value, input int bits);
        logic signed [xlen-1:0] shifted;
        shifted = value << (xlen - bits);
        return shifted >>> (xlen - bits);
    endfunction

    function automatic logic [xlen-1:0] zero_extend(input logic [xlen-1:0] value, input int bits);
        return value & ((64'd1 << bits) - 64'd1);
    endfunction

    task automatic bus_write(input logic [xlen-1:0] addr, input ls_type_e kind,
                             input logic [xlen-1:0] data);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_ls_type <= kind;
        bus_write_data <= data;
        bus_write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        // done drops after the sampling edge
        @(negedge CLOCK_50);
        compare_values("write done dropped", 64'd0, 64'(bus_write_done));
        while (!bus_write_done) @(negedge CLOCK_50);
    endtask

    task automatic bus_read(input logic [xlen-1:0] addr, input ls_type_e kind,
                            output logic [xlen-1:0] data);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_ls_type <= kind;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        @(negedge CLOCK_50);
        compare_values("read done dropped", 64'd0, 64'(bus_read_done));
        while (!bus_read_done) @(negedge CLOCK_50);
        data = bus_read_data;
    endtask

    // rising edge on the uart line, seen by the PLIC one edge later
    task automatic pulse_uart();
        @(posedge CLOCK_50);
        uart_irq <= 1'b1;
        @(posedge CLOCK_50);
        uart_irq <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    task automatic test_reset_values();
        logic [xlen-1:0] data;
        @(negedge CLOCK_50);
        compare_values("reset read done", 64'd1, 64'(bus_read_done));
        compare_values("reset write done", 64'd1, 64'(bus_write_done));
        compare_values("reset read data", 64'd0, bus_read_data);
        compare_values("reset mtimecmp port", mtimecmp_reset, mtimecmp);
        compare_values("reset meip", 64'd0, 64'(meip_interrupt));
        compare_values("reset msip", 64'd0, 64'(msip_interrupt));
        bus_read(mtimecmp_addr, ls_d, data);
        compare_values("reset mtimecmp read", mtimecmp_reset, data);
    endtask

    task automatic test_ram_words();
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        logic [xlen-1:0] data;
        for (int i = 0; i < 4; i++) begin
            addr = ram_base + 64'(($urandom % (ram_words / 2)) * 8);
            value = {$urandom, $urandom};
            value[31] = i[0];
            bus_write(addr, ls_w, value);
            bus_read(addr, ls_w, data);
            compare_values("lw", sign_extend(value, 32), data);
            bus_read(addr, ls_wu, data);
            compare_values("lwu", zero_extend(value, 32), data);
            // fresh value so both words of sd are new
            value = {$urandom, $urandom};
            bus_write(addr, ls_d, value);
            bus_read(addr, ls_d, data);
            compare_values("ld", value, data);
            bus_read(addr + 64'd4, ls_wu, data);
            compare_values("sd upper word", value >> 32, data);
        end
    endtask

    task automatic test_ram_lanes();
        logic [xlen-1:0] base;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] data;
        logic [31:0] model;
        logic [15:0] half;
        logic [7:0] lane;
        base = ram_base + 64'h40;
        model = $urandom;
        bus_write(base, ls_w, 64'(model));
        for (int off = 0; off < 4; off++) begin
            lane = 8'($urandom);
            lane[7] = off[0];
            model[off*8 +: 8] = lane;
            // junk above the lane must not be stored
            wdata = {$urandom, $urandom};
            wdata[7:0] = lane;
            bus_write(base + 64'(off), ls_b, wdata);
            bus_read(base, ls_wu, data);
            compare_values("sb word", 64'(model), data);
            bus_read(base + 64'(off), ls_b, data);
            compare_values("lb", sign_extend(64'(lane), 8), data);
            bus_read(base + 64'(off), ls_bu, data);
            compare_values("lbu", 64'(lane), data);
        end
        for (int off = 0; off < 4; off += 2) begin
            half = 16'($urandom);
            half[15] = off[1];
            model[off*8 +: 16] = half;
            wdata = {$urandom, $urandom};
            wdata[15:0] = half;
            bus_write(base + 64'(off), ls_h, wdata);
            bus_read(base, ls_wu, data);
            compare_values("sh word", 64'(model), data);
            bus_read(base + 64'(off), ls_h, data);
            compare_values("lh", sign_extend(64'(half), 16), data);
            bus_read(base + 64'(off), ls_hu, data);
            compare_values("lhu", 64'(half), data);
        end
    endtask

    task automatic test_timer_key();
        logic [xlen-1:0] value;
        logic [xlen-1:0] data;
        @(posedge CLOCK_50);
        mtime <= {$urandom, $urandom};
        // top bit set so zero extension is visible
        key_ascii <= 8'h80 | 8'($urandom);
        value = {$urandom, $urandom};
        bus_write(mtimecmp_addr, ls_d, value);
        compare_values("mtimecmp port", value, mtimecmp);
        bus_read(mtimecmp_addr, ls_d, data);
        compare_values("mtimecmp read", value, data);
        bus_read(mtime_addr, ls_d, data);
        compare_values("mtime read", mtime, data);
        bus_read(key_addr, ls_bu, data);
        compare_values("key read", 64'(key_ascii), data);
        bus_read(64'h0000_0000_4000_0000, ls_d, data);
        compare_values("unmapped read", 64'd0, data);
    endtask

    task automatic test_plic_claim();
        logic [xlen-1:0] data;
        bus_write(plic_base + plic_enable_off, ls_w, 64'h2);
        pulse_uart();
        compare_values("meip raised", 64'd1, 64'(meip_interrupt));
        compare_values("msip idle", 64'd0, 64'(msip_interrupt));
        bus_read(plic_base + plic_pending_off, ls_w, data);
        compare_values("pending set", 64'h2, data);
        bus_read(plic_base + plic_claim_off, ls_w, data);
        compare_values("claim context 0", 64'd1, data);
        compare_values("meip cleared", 64'd0, 64'(meip_interrupt));
        bus_read(plic_base + plic_pending_off, ls_w, data);
        compare_values("pending cleared", 64'd0, data);
        // context 1 alone
        bus_write(plic_base + plic_enable_off, ls_w, 64'h0);
        bus_write(plic_base + plic_enable_off + plic_ctx_enable_stride, ls_w, 64'h2);
        pulse_uart();
        compare_values("msip raised", 64'd1, 64'(msip_interrupt));
        compare_values("meip idle", 64'd0, 64'(meip_interrupt));
        bus_read(plic_base + plic_claim_off + plic_ctx_stride, ls_w, data);
        compare_values("claim context 1", 64'd1, data);
        compare_values("msip cleared", 64'd0, 64'(msip_interrupt));
        bus_write(plic_base + plic_claim_off + plic_ctx_stride, ls_w, 64'd1);
    endtask

    task automatic test_plic_registers();
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        logic [xlen-1:0] data;
        for (int src = 1; src < plic_sources; src++) begin
            addr = plic_base + 64'(src * 4);
            // nonzero, the reset value would hide a lost write
            value = 64'(($urandom % ((1 << plic_prio_bits) - 1)) + 1);
            bus_write(addr, ls_w, value);
            bus_read(addr, ls_w, data);
            compare_values("priority", value, data);
        end
        for (int ctx = 0; ctx < plic_contexts; ctx++) begin
            addr = plic_base + plic_threshold_off + 64'(ctx) * plic_ctx_stride;
            value = 64'(($urandom % ((1 << plic_prio_bits) - 1)) + 1);
            bus_write(addr, ls_w, value);
            bus_read(addr, ls_w, data);
            compare_values("threshold", value, data);
        end
    endtask

    initial begin
        void'($urandom(94));
        KEY0 = 1'b1;
        bus_address = '0;
        bus_ls_type = ls_w;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        key_ascii = '0;
        mtime = '0;
        uart_irq = 1'b0;
        #1 KEY0 = 1'b0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        test_reset_values();
        test_ram_words();
        test_ram_lanes();
        test_timer_key();
        test_plic_claim();
        test_plic_registers();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== sim/soc_bus_properties.sv ====
`timescale 1ns/1ps

module soc_bus_properties (
    input logic CLOCK_50,
    input logic KEY0,
    input logic [bus_pkg::xlen-1:0] bus_address,
    input logic bus_read_done,
    input logic bus_write_done
);
    logic [2:0] read_low_cycles;
    logic [2:0] write_low_cycles;

    // cycles spent with each done low
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_low_cycles <= '0;
            write_low_cycles <= '0;
        end else begin
            read_low_cycles <= bus_read_done ? 3'd0 : read_low_cycles + 3'd1;
            write_low_cycles <= bus_write_done ? 3'd0 : write_low_cycles + 3'd1;
        end
    end

    read_done_returns: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_low_cycles <= 3'd4)
        else $error("read done stayed low for more than four cycles");

    write_done_returns: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        write_low_cycles <= 3'd4)
        else $error("write done stayed low for more than four cycles");

    done_high_in_reset: assert property (@(posedge CLOCK_50)
        !KEY0 |-> (bus_read_done && bus_write_done))
        else $error("done outputs not high during reset");

    // the CPU keeps the address until the access completes
    address_held: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (!bus_read_done || !bus_write_done) |-> $stable(bus_address))
        else $error("bus address changed while an access was in flight");

endmodule

bind soc_bus soc_bus_properties soc_bus_properties_i (
    .CLOCK_50       (CLOCK_50),
    .KEY0           (KEY0),
    .bus_address    (bus_address),
    .bus_read_done  (bus_read_done),
    .bus_write_done (bus_write_done)
);

// ==== design/soc_bus.sv ====
`timescale 1ns/1ps

module soc_bus (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [bus_pkg::xlen-1:0] bus_address,
    input  bus_pkg::ls_type_e bus_ls_type,
    input  logic [bus_pkg::xlen-1:0] bus_write_data,
    input  logic bus_read_enable,
    input  logic bus_write_enable,
    output logic [bus_pkg::xlen-1:0] bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    input  logic [7:0] key_ascii,
    input  logic [bus_pkg::xlen-1:0] mtime,
    output logic [bus_pkg::xlen-1:0] mtimecmp,
    input  logic uart_irq,
    output logic meip_interrupt,
    output logic msip_interrupt
);

    periph_if ram_bus ();
    periph_if plic_bus ();

    // decoder and local registers
    bus_ctrl bus_ctrl_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_ls_type      (bus_ls_type),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .key_ascii        (key_ascii),
        .mtime            (mtime),
        .mtimecmp         (mtimecmp),
        .ram              (ram_bus.ctrl),
        .plic_port        (plic_bus.ctrl)
    );

    ram_port ram_port_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus.target)
    );

    plic plic_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus            (plic_bus.target),
        .uart_irq       (uart_irq),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

// ==== design/plic.sv ====
`timescale 1ns/1ps

module plic (
    input  logic CLOCK_50,
    input  logic KEY0,
    periph_if.target bus,
    input  logic uart_irq,
    output logic meip_interrupt,
    output logic msip_interrupt
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    localparam int prio_idx_bits = $clog2(plic_sources);

    logic [plic_prio_bits-1:0] prio_q [plic_sources];
    logic [31:0] pending_q;
    logic [31:0] enable_q [plic_contexts];
    logic [plic_prio_bits-1:0] threshold_q [plic_contexts];
    logic [31:0] claim_id [plic_contexts];
    logic uart_irq_q;

    logic prio_hit;
    logic [prio_idx_bits-1:0] prio_idx;
    logic [plic_contexts-1:0] enable_hit;
    logic [plic_contexts-1:0] threshold_hit;
    logic [plic_contexts-1:0] claim_hit;
    logic [xlen-1:0] read_value;

    // one priority word per source id
    assign prio_idx = bus.offset[prio_idx_bits+1:2];
    assign prio_hit = (bus.offset < plic_pending_off) && (bus.offset[xlen-1:2] < plic_sources);

    always_comb begin
        for (int c = 0; c < plic_contexts; c++) begin
            enable_hit[c] = (bus.offset == plic_enable_off + c * plic_ctx_enable_stride);
            threshold_hit[c] = (bus.offset == plic_threshold_off + c * plic_ctx_stride);
            claim_hit[c] = (bus.offset == plic_claim_off + c * plic_ctx_stride);
            // only the uart source exists, threshold is not compared
            claim_id[c] = (pending_q[1] && enable_q[c][1]) ? 32'd1 : 32'd0;
        end
    end

    always_comb begin
        read_value = '0;
        if (prio_hit) begin
            read_value[plic_prio_bits-1:0] = prio_q[prio_idx];
        end
        if (bus.offset == plic_pending_off) begin
            read_value[31:0] = pending_q;
        end
        for (int c = 0; c < plic_contexts; c++) begin
            if (enable_hit[c]) read_value[31:0] = enable_q[c];
            if (threshold_hit[c]) read_value[plic_prio_bits-1:0] = threshold_q[c];
            if (claim_hit[c]) read_value[31:0] = claim_id[c];
        end
    end

    assign meip_interrupt = (claim_id[0] != '0);
    assign msip_interrupt = (claim_id[1] != '0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack <= 1'b0;
            pending_q <= '0;
            uart_irq_q <= 1'b0;
            for (int s = 0; s < plic_sources; s++) prio_q[s] <= '0;
            for (int c = 0; c < plic_contexts; c++) begin
                enable_q[c] <= '0;
                threshold_q[c] <= '0;
            end
        end else begin
            bus.ack <= 1'b0;
            uart_irq_q <= uart_irq;
            if (bus.rd && !bus.ack) begin
                bus.ack <= 1'b1;
                // claim read retires the claimed source
                for (int c = 0; c < plic_contexts; c++) begin
                    if (claim_hit[c] && claim_id[c] != '0) pending_q[claim_id[c][4:0]] <= 1'b0;
                end
            end
            if (bus.wr && !bus.ack) begin
                bus.ack <= 1'b1;
                if (prio_hit) prio_q[prio_idx] <= bus.wdata[plic_prio_bits-1:0];
                for (int c = 0; c < plic_contexts; c++) begin
                    if (enable_hit[c]) enable_q[c] <= bus.wdata[31:0];
                    if (threshold_hit[c]) threshold_q[c] <= bus.wdata[plic_prio_bits-1:0];
                end
            end
            // uart line is source 1, latched on its rising edge
            if (uart_irq && !uart_irq_q) pending_q[1] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.rd && !bus.ack) bus.rdata <= read_value;
    end

endmodule

// ==== design/ram_port.sv ====
`timescale 1ns/1ps

module ram_port (
    input logic CLOCK_50,
    input logic KEY0,
    periph_if.target bus
);
    import bus_pkg::*;

    typedef enum logic {
        step_first,
        step_second
    } step_e;

    logic [31:0] mem [2**ram_addr_bits];
    step_e step;

    logic [ram_addr_bits-1:0] word_idx;
    logic [ram_addr_bits-1:0] next_idx;
    logic [1:0] byte_off;
    logic [31:0] shifted;
    logic [xlen-1:0] load_value;
    logic access;

    assign word_idx = bus.offset[ram_addr_bits+1:2];
    assign next_idx = word_idx + 1'b1;
    assign byte_off = bus.offset[1:0];

    // new request, not yet acknowledged
    assign access = (bus.rd || bus.wr) && !bus.ack;

    // addressed lane moved down to bit 0
    assign shifted = mem[word_idx] >> {byte_off, 3'b000};

    always_comb begin
        case (bus.ls_type)
            ls_b:    load_value = {{(xlen - 8){shifted[7]}}, shifted[7:0]};
            ls_h:    load_value = {{(xlen - 16){shifted[15]}}, shifted[15:0]};
            ls_w:    load_value = {{(xlen - 32){shifted[31]}}, shifted};
            ls_bu:   load_value = {{(xlen - 8){1'b0}}, shifted[7:0]};
            ls_hu:   load_value = {{(xlen - 16){1'b0}}, shifted[15:0]};
            default: load_value = {{(xlen - 32){1'b0}}, shifted};
        endcase
    end

    // double accesses take a second step before ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack <= 1'b0;
            step <= step_first;
        end else begin
            bus.ack <= 1'b0;
            if (access) begin
                if (bus.ls_type == ls_d && step == step_first) begin
                    step <= step_second;
                end else begin
                    step <= step_first;
                    bus.ack <= 1'b1;
                end
            end
        end
    end

    // read data, low word first for ld
    always_ff @(posedge CLOCK_50) begin
        if (bus.rd && !bus.ack) begin
            if (bus.ls_type == ls_d) begin
                if (step == step_first) begin
                    bus.rdata[31:0] <= mem[word_idx];
                end else begin
                    bus.rdata[63:32] <= mem[next_idx];
                end
            end else begin
                bus.rdata <= load_value;
            end
        end
    end

    // stores touch only their lane
    always_ff @(posedge CLOCK_50) begin
        if (bus.wr && !bus.ack) begin
            case (bus.ls_type)
                ls_b: mem[word_idx][{byte_off, 3'b000} +: 8] <= bus.wdata[7:0];
                ls_h: mem[word_idx][{byte_off[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                ls_w: mem[word_idx] <= bus.wdata[31:0];
                ls_d: begin
                    if (step == step_first) begin
                        mem[word_idx] <= bus.wdata[31:0];
                    end else begin
                        mem[next_idx] <= bus.wdata[63:32];
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== design/bus_ctrl.sv ====
`timescale 1ns/1ps

module bus_ctrl (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic [bus_pkg::xlen-1:0] bus_address,
    input  bus_pkg::ls_type_e bus_ls_type,
    input  logic [bus_pkg::xlen-1:0] bus_write_data,
    input  logic bus_read_enable,
    input  logic bus_write_enable,
    output logic [bus_pkg::xlen-1:0] bus_read_data,
    output logic bus_read_done,
    output logic bus_write_done,
    input  logic [7:0] key_ascii,
    input  logic [bus_pkg::xlen-1:0] mtime,
    output logic [bus_pkg::xlen-1:0] mtimecmp,
    periph_if.ctrl ram,
    periph_if.ctrl plic_port
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    region_e region;

    // address decode, the CPU holds the address for the whole access
    always_comb begin
        region = region_none;
        if (bus_address >= ram_base && bus_address < ram_base + ram_words * 4) begin
            region = region_ram;
        end else if (bus_address == key_addr) begin
            region = region_key;
        end else if (bus_address == mtime_addr) begin
            region = region_mtime;
        end else if (bus_address == mtimecmp_addr) begin
            region = region_mtimecmp;
        end else if (bus_address >= plic_base && bus_address < plic_base + plic_span) begin
            region = region_plic;
        end
    end

    // targets only see offsets into their own window
    assign ram.offset = bus_address - ram_base;
    assign ram.wdata = bus_write_data;
    assign ram.ls_type = bus_ls_type;
    assign plic_port.offset = bus_address - plic_base;
    assign plic_port.wdata = bus_write_data;
    assign plic_port.ls_type = bus_ls_type;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data <= '0;
            mtimecmp <= mtimecmp_reset;
            ram.rd <= 1'b0;
            ram.wr <= 1'b0;
            plic_port.rd <= 1'b0;
            plic_port.wr <= 1'b0;
        end else begin
            // read direction
            if (bus_read_enable && bus_read_done) begin
                bus_read_done <= 1'b0;
                ram.rd <= (region == region_ram);
                plic_port.rd <= (region == region_plic);
            end else if (!bus_read_done) begin
                case (region)
                    region_ram: begin
                        if (ram.ack) begin
                            bus_read_data <= ram.rdata;
                            bus_read_done <= 1'b1;
                            ram.rd <= 1'b0;
                        end
                    end
                    region_plic: begin
                        if (plic_port.ack) begin
                            bus_read_data <= plic_port.rdata;
                            bus_read_done <= 1'b1;
                            plic_port.rd <= 1'b0;
                        end
                    end
                    region_key: begin
                        bus_read_data <= {{(xlen - 8){1'b0}}, key_ascii};
                        bus_read_done <= 1'b1;
                    end
                    region_mtime: begin
                        bus_read_data <= mtime;
                        bus_read_done <= 1'b1;
                    end
                    region_mtimecmp: begin
                        bus_read_data <= mtimecmp;
                        bus_read_done <= 1'b1;
                    end
                    default: begin
                        // unmapped reads complete with zero
                        bus_read_data <= '0;
                        bus_read_done <= 1'b1;
                    end
                endcase
            end

            // write direction
            if (bus_write_enable && bus_write_done) begin
                bus_write_done <= 1'b0;
                ram.wr <= (region == region_ram);
                plic_port.wr <= (region == region_plic);
            end else if (!bus_write_done) begin
                case (region)
                    region_ram: begin
                        if (ram.ack) begin
                            bus_write_done <= 1'b1;
                            ram.wr <= 1'b0;
                        end
                    end
                    region_plic: begin
                        if (plic_port.ack) begin
                            bus_write_done <= 1'b1;
                            plic_port.wr <= 1'b0;
                        end
                    end
                    region_mtimecmp: begin
                        mtimecmp <= bus_write_data;
                        bus_write_done <= 1'b1;
                    end
                    // key and mtime are read only, unmapped writes are dropped
                    default: bus_write_done <= 1'b1;
                endcase
            end
        end
    end

endmodule

// ==== design/periph_if.sv ====
`timescale 1ns/1ps

interface periph_if;
    import bus_pkg::*;

    // request side, held as a level until ack
    logic rd;
    logic wr;
    logic [xlen-1:0] offset;
    logic [xlen-1:0] wdata;
    ls_type_e ls_type;

    // one-cycle acknowledge with its read data
    logic [xlen-1:0] rdata;
    logic ack;

    modport ctrl (output rd, wr, offset, wdata, ls_type, input rdata, ack);

    modport target (input rd, wr, offset, wdata, ls_type, output rdata, ack);

endinterface

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

    // on-chip word RAM
    localparam logic [63:0] ram_base = 64'h0000_0000_8000_0000;
    localparam int ram_words = 2048;

    // keyboard character register
    localparam logic [63:0] key_addr = 64'h0000_0000_1000_0000;

    // machine timer registers
    localparam logic [63:0] mtime_addr = 64'h0000_0000_0200_BFF8;
    localparam logic [63:0] mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [63:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    // PLIC window and its register offsets
    localparam logic [63:0] plic_base = 64'h0000_0000_0C00_0000;
    localparam logic [63:0] plic_span = 64'h0000_0000_0040_0000;
    localparam logic [63:0] plic_pending_off = 64'h0000_0000_0000_1000;
    localparam logic [63:0] plic_enable_off = 64'h0000_0000_0000_2000;
    localparam logic [63:0] plic_ctx_enable_stride = 64'h0000_0000_0000_0080;
    localparam logic [63:0] plic_threshold_off = 64'h0000_0000_0020_0000;
    localparam logic [63:0] plic_claim_off = 64'h0000_0000_0020_0004;
    localparam logic [63:0] plic_ctx_stride = 64'h0000_0000_0000_1000;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

    // address and data width of the load/store bus
    localparam int xlen = 64;

    // word index width of the on-chip RAM
    localparam int ram_addr_bits = 11;

    // load/store size and extension, stores only use ls_b to ls_d
    typedef enum logic [2:0] {
        ls_b  = 3'd0,
        ls_h  = 3'd1,
        ls_w  = 3'd2,
        ls_d  = 3'd3,
        ls_bu = 3'd4,
        ls_hu = 3'd5,
        ls_wu = 3'd6
    } ls_type_e;

    // targets known to the address decoder
    typedef enum logic [2:0] {
        region_none,
        region_ram,
        region_key,
        region_mtime,
        region_mtimecmp,
        region_plic
    } region_e;

    // interrupt controller sizes
    localparam int plic_sources = 6;
    localparam int plic_prio_bits = 3;
    localparam int plic_contexts = 2;

endpackage
